//--- sdram_sched_pkg.sv
package sdram_sched_pkg;

  ////////////////////
  // Widths

  localparam int BA_W      = 2;
  localparam int NUM_BANKS = 1 << BA_W;
  localparam int ROW_W     = 11;
  localparam int COL_W     = 8;
  localparam int DQ_W      = 16;
  localparam int DM_W      = DQ_W / 8;

  // Pin encoding {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_NOP = 4'b0111,
    CMD_ACT = 4'b0011,
    CMD_RD  = 4'b0101,
    CMD_WR  = 4'b0100,
    CMD_PRE = 4'b0010,
    CMD_REF = 4'b0001
  } sdram_cmd_e;

  ////////////////////
  // Control and status registers

  typedef struct packed {
    logic        ena;
    logic [1:0]  cl;
    logic [3:0]  t_rcd;
    logic [3:0]  t_rp;
    logic [3:0]  t_ras;
    logic [3:0]  t_rc;
    logic [15:0] t_ref;
  } csr_t;

  localparam csr_t CSR_RESET = '{
    ena:   1'b0,
    cl:    2'd2,
    t_rcd: 4'd2,
    t_rp:  4'd2,
    t_ras: 4'd5,
    t_rc:  4'd7,
    t_ref: 16'd400
  };

  // CTRL holds ena at bit 0 and cl at bits 5:4
  // TIMING holds t_rcd in 3:0, t_rp in 7:4, t_ras in 11:8 and t_rc in 15:12
  localparam logic [3:0] CSR_CTRL   = 4'h0;
  localparam logic [3:0] CSR_TIMING = 4'h4;
  localparam logic [3:0] CSR_TREF   = 4'h8;

  ////////////////////
  // Host side and internal command

  typedef struct packed {
    logic             we;
    logic [BA_W-1:0]  ba;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic [DQ_W-1:0]  wdata;
    logic [DM_W-1:0]  be;
  } req_t;

  typedef struct packed {
    logic [DQ_W-1:0] rdata;
  } rsp_t;

  // Command as issued by the FSM
  // Field all marks a precharge of every bank
  typedef struct packed {
    sdram_cmd_e       cmd;
    logic             all;
    logic [BA_W-1:0]  ba;
    logic [ROW_W-1:0] row;
  } bank_cmd_t;

endpackage

//--- sdram_csr_apb.sv
`timescale 1ns/100ps

module sdram_csr_apb (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [3:0]            paddr_i,
  input  logic [31:0]           pwdata_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output sdram_sched_pkg::csr_t csr_o
);
  import sdram_sched_pkg::*;

  logic access;
  logic addr_hit;

  // Access phase of an APB transfer
  assign access   = psel_i & penable_i;
  assign addr_hit = (paddr_i == CSR_CTRL) || (paddr_i == CSR_TIMING) || (paddr_i == CSR_TREF);

  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~addr_hit;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      csr_o <= CSR_RESET;
    end
    else if (access && pwrite_i)
    begin
      case (paddr_i)
        CSR_CTRL:
        begin
          csr_o.ena <= pwdata_i[0];
          csr_o.cl  <= pwdata_i[5:4];
        end
        CSR_TIMING:
        begin
          csr_o.t_rcd <= pwdata_i[3:0];
          csr_o.t_rp  <= pwdata_i[7:4];
          csr_o.t_ras <= pwdata_i[11:8];
          csr_o.t_rc  <= pwdata_i[15:12];
        end
        CSR_TREF:
          csr_o.t_ref <= pwdata_i[15:0];
        default: ;
      endcase
    end
  end

  // Read back mirrors the write layout
  always_comb
  begin
    case (paddr_i)
      CSR_CTRL:   prdata_o = {26'd0, csr_o.cl, 3'd0, csr_o.ena};
      CSR_TIMING: prdata_o = {16'd0, csr_o.t_rc, csr_o.t_ras, csr_o.t_rp, csr_o.t_rcd};
      CSR_TREF:   prdata_o = {16'd0, csr_o.t_ref};
      default:    prdata_o = 32'd0;
    endcase
  end

endmodule

//--- sdram_bank_timers.sv
`timescale 1ns/100ps

module sdram_bank_timers (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  sdram_sched_pkg::csr_t                 csr_i,
  input  sdram_sched_pkg::bank_cmd_t            cmd_i,
  output logic [sdram_sched_pkg::NUM_BANKS-1:0] bank_open_o,
  output logic [sdram_sched_pkg::NUM_BANKS-1:0][sdram_sched_pkg::ROW_W-1:0] open_row_o,
  output logic [sdram_sched_pkg::NUM_BANKS-1:0] rcd_done_o,
  output logic [sdram_sched_pkg::NUM_BANKS-1:0] rp_done_o,
  output logic [sdram_sched_pkg::NUM_BANKS-1:0] ras_done_o,
  output logic                                  rc_done_o
);
  import sdram_sched_pkg::*;

  // Timer slots are tRCD per bank, tRP per bank, tRAS per bank and the shared tRC last
  localparam int RCD = 0;
  localparam int RP  = NUM_BANKS;
  localparam int RAS = 2 * NUM_BANKS;
  localparam int RC  = 3 * NUM_BANKS;
  localparam int NT  = 3 * NUM_BANKS + 1;

  logic [NUM_BANKS-1:0] act_bank;
  logic [NUM_BANKS-1:0] pre_bank;
  logic [NT-1:0]        ld;
  logic [NT-1:0][3:0]   ld_val;
  logic [NT-1:0][3:0]   cnt;
  logic [NT-1:0]        done;

  ////////////////////
  // Load decode

  always_comb
  begin
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      act_bank[b]   = (cmd_i.cmd == CMD_ACT) && (cmd_i.ba == BA_W'(b));
      pre_bank[b]   = (cmd_i.cmd == CMD_PRE) && (cmd_i.all || (cmd_i.ba == BA_W'(b)));
      ld[RCD+b]     = act_bank[b];
      ld_val[RCD+b] = csr_i.t_rcd;
      ld[RP+b]      = pre_bank[b];
      ld_val[RP+b]  = csr_i.t_rp;
      ld[RAS+b]     = act_bank[b];
      ld_val[RAS+b] = csr_i.t_ras;
    end
    ld[RC]     = (cmd_i.cmd == CMD_ACT) || (cmd_i.cmd == CMD_REF);
    ld_val[RC] = csr_i.t_rc;
  end

  ////////////////////
  // Countdowns

  // Loading N-1 puts done high exactly N cycles after the load
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cnt  <= '0;
      done <= '1;
    end
    else
    begin
      for (int i = 0; i < NT; i++)
      begin
        if (ld[i])
        begin
          cnt[i]  <= ld_val[i] - 4'd1;
          done[i] <= ld_val[i] <= 4'd1;
        end
        else if (!done[i])
        begin
          cnt[i]  <= cnt[i] - 4'd1;
          done[i] <= cnt[i] == 4'd1;
        end
      end
    end
  end

  ////////////////////
  // Row state

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      bank_open_o <= '0;
    else
      bank_open_o <= (bank_open_o | act_bank) & ~pre_bank;
  end

  always_ff @(posedge clk_i)
  begin
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      if (act_bank[b])
        open_row_o[b] <= cmd_i.row;
    end
  end

  assign rcd_done_o = done[RCD +: NUM_BANKS];
  assign rp_done_o  = done[RP +: NUM_BANKS];
  assign ras_done_o = done[RAS +: NUM_BANKS];
  assign rc_done_o  = done[RC];

endmodule

//--- sdram_refresh_ctrl.sv
`timescale 1ns/100ps

module sdram_refresh_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  sdram_sched_pkg::csr_t csr_i,
  input  logic                  ref_issued_i,
  output logic                  ref_pending_o
);

  logic [15:0] ref_cnt;

  // Interval counter reloaded with t_ref-1 so one period is t_ref cycles
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ref_cnt <= '0;
    else if (!csr_i.ena || (ref_cnt == 16'd0))
      ref_cnt <= csr_i.t_ref - 16'd1;
    else
      ref_cnt <= ref_cnt - 16'd1;
  end

  // A new interval wins over a REF in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ref_pending_o <= 1'b0;
    else if (csr_i.ena && (ref_cnt == 16'd0))
      ref_pending_o <= 1'b1;
    else if (ref_issued_i)
      ref_pending_o <= 1'b0;
  end

endmodule

//--- sdram_cmd_fsm.sv
`timescale 1ns/100ps

module sdram_cmd_fsm (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  sdram_sched_pkg::csr_t                 csr_i,
  input  logic                                  req_valid_i,
  input  sdram_sched_pkg::req_t                 req_i,
  output logic                                  req_ready_o,
  input  logic [sdram_sched_pkg::NUM_BANKS-1:0] bank_open_i,
  input  logic [sdram_sched_pkg::NUM_BANKS-1:0][sdram_sched_pkg::ROW_W-1:0] open_row_i,
  input  logic [sdram_sched_pkg::NUM_BANKS-1:0] rcd_done_i,
  input  logic [sdram_sched_pkg::NUM_BANKS-1:0] rp_done_i,
  input  logic [sdram_sched_pkg::NUM_BANKS-1:0] ras_done_i,
  input  logic                                  rc_done_i,
  input  logic                                  ref_pending_i,
  output sdram_sched_pkg::bank_cmd_t            cmd_o,
  output logic                                  ref_issued_o,
  output logic                                  rd_issued_o,
  output sdram_sched_pkg::sdram_cmd_e           sdram_cmd_o,
  output logic [sdram_sched_pkg::BA_W-1:0]      sdram_ba_o,
  output logic [sdram_sched_pkg::ROW_W-1:0]     sdram_addr_o,
  output logic [sdram_sched_pkg::DQ_W-1:0]      sdram_dq_o,
  output logic                                  sdram_dqoe_o,
  output logic [sdram_sched_pkg::DM_W-1:0]      sdram_dm_o
);
  import sdram_sched_pkg::*;

  logic             row_hit;
  logic [ROW_W-1:0] nxt_addr;

  assign row_hit = bank_open_i[req_i.ba] && (open_row_i[req_i.ba] == req_i.row);

  ////////////////////
  // Command decision

  always_comb
  begin
    cmd_o.cmd = CMD_NOP;
    cmd_o.all = 1'b0;
    cmd_o.ba  = req_i.ba;
    cmd_o.row = req_i.row;
    if (csr_i.ena)
    begin
      if (ref_pending_i)
      begin
        // Close all rows, then refresh
        if (|bank_open_i)
        begin
          if (&ras_done_i)
          begin
            cmd_o.cmd = CMD_PRE;
            cmd_o.all = 1'b1;
          end
        end
        else if (&rp_done_i && rc_done_i)
          cmd_o.cmd = CMD_REF;
      end
      else if (req_valid_i)
      begin
        if (row_hit)
        begin
          if (rcd_done_i[req_i.ba])
            cmd_o.cmd = req_i.we ? CMD_WR : CMD_RD;
        end
        // Wrong row open in this bank
        else if (bank_open_i[req_i.ba])
        begin
          if (ras_done_i[req_i.ba])
            cmd_o.cmd = CMD_PRE;
        end
        else if (rp_done_i[req_i.ba] && rc_done_i)
          cmd_o.cmd = CMD_ACT;
      end
    end
  end

  assign req_ready_o  = (cmd_o.cmd == CMD_RD) || (cmd_o.cmd == CMD_WR);
  assign rd_issued_o  = cmd_o.cmd == CMD_RD;
  assign ref_issued_o = cmd_o.cmd == CMD_REF;

  // Bit 10 selects all banks on PRE and stays low for RD and WR
  always_comb
  begin
    nxt_addr = '0;
    case (cmd_o.cmd)
      CMD_ACT:        nxt_addr = cmd_o.row;
      CMD_RD, CMD_WR: nxt_addr = ROW_W'(req_i.col);
      CMD_PRE:        nxt_addr[10] = cmd_o.all;
      default:        nxt_addr = '0;
    endcase
  end

  ////////////////////
  // Pin registers

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      sdram_cmd_o  <= CMD_NOP;
      sdram_dqoe_o <= 1'b0;
    end
    else
    begin
      sdram_cmd_o  <= cmd_o.cmd;
      sdram_dqoe_o <= cmd_o.cmd == CMD_WR;
    end
  end

  // Data and mask travel with the WR command
  always_ff @(posedge clk_i)
  begin
    sdram_ba_o   <= cmd_o.ba;
    sdram_addr_o <= nxt_addr;
    sdram_dq_o   <= req_i.wdata;
    sdram_dm_o   <= ~req_i.be;
  end

endmodule

//--- sdram_rd_return.sv
`timescale 1ns/100ps

module sdram_rd_return #(
  parameter int MAX_CL = 3
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  sdram_sched_pkg::csr_t                csr_i,
  input  logic                                 rd_issued_i,
  input  logic [sdram_sched_pkg::DQ_W-1:0]     sdram_dq_i,
  output logic                                 rsp_valid_o,
  output sdram_sched_pkg::rsp_t                rsp_o
);

  // Stage k is high k cycles after RD reaches the pins
  logic [MAX_CL:0] rd_pipe;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rd_pipe     <= '0;
      rsp_valid_o <= 1'b0;
    end
    else
    begin
      rd_pipe     <= {rd_pipe[MAX_CL-1:0], rd_issued_i};
      rsp_valid_o <= rd_pipe[csr_i.cl];
    end
  end

  // Capture while the memory drives the read word
  always_ff @(posedge clk_i)
  begin
    if (rd_pipe[csr_i.cl])
      rsp_o.rdata <= sdram_dq_i;
  end

endmodule

//--- sdram_scheduler_top.sv
`timescale 1ns/100ps

module sdram_scheduler_top #(
  parameter int MAX_CL = 3
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [3:0]                        paddr_i,
  input  logic [31:0]                       pwdata_i,
  output logic [31:0]                       prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  input  logic                              req_valid_i,
  input  sdram_sched_pkg::req_t             req_i,
  output logic                              req_ready_o,
  output logic                              rsp_valid_o,
  output sdram_sched_pkg::rsp_t             rsp_o,
  output sdram_sched_pkg::sdram_cmd_e       sdram_cmd_o,
  output logic [sdram_sched_pkg::BA_W-1:0]  sdram_ba_o,
  output logic [sdram_sched_pkg::ROW_W-1:0] sdram_addr_o,
  output logic [sdram_sched_pkg::DQ_W-1:0]  sdram_dq_o,
  output logic                              sdram_dqoe_o,
  output logic [sdram_sched_pkg::DM_W-1:0]  sdram_dm_o,
  input  logic [sdram_sched_pkg::DQ_W-1:0]  sdram_dq_i
);
  import sdram_sched_pkg::*;

  csr_t                             csr;
  bank_cmd_t                        bank_cmd;
  logic [NUM_BANKS-1:0]             bank_open;
  logic [NUM_BANKS-1:0][ROW_W-1:0]  open_row;
  logic [NUM_BANKS-1:0]             rcd_done;
  logic [NUM_BANKS-1:0]             rp_done;
  logic [NUM_BANKS-1:0]             ras_done;
  logic                             rc_done;
  logic                             ref_pending;
  logic                             ref_issued;
  logic                             rd_issued;

  sdram_csr_apb u_csr (
    .clk_i, .rst_ni, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .csr_o (csr)
  );

  sdram_bank_timers u_timers (
    .clk_i, .rst_ni,
    .csr_i       (csr),
    .cmd_i       (bank_cmd),
    .bank_open_o (bank_open),
    .open_row_o  (open_row),
    .rcd_done_o  (rcd_done),
    .rp_done_o   (rp_done),
    .ras_done_o  (ras_done),
    .rc_done_o   (rc_done)
  );

  sdram_refresh_ctrl u_refresh (
    .clk_i, .rst_ni,
    .csr_i         (csr),
    .ref_issued_i  (ref_issued),
    .ref_pending_o (ref_pending)
  );

  sdram_cmd_fsm u_fsm (
    .clk_i, .rst_ni,
    .csr_i         (csr),
    .req_valid_i, .req_i, .req_ready_o,
    .bank_open_i   (bank_open),
    .open_row_i    (open_row),
    .rcd_done_i    (rcd_done),
    .rp_done_i     (rp_done),
    .ras_done_i    (ras_done),
    .rc_done_i     (rc_done),
    .ref_pending_i (ref_pending),
    .cmd_o         (bank_cmd),
    .ref_issued_o  (ref_issued),
    .rd_issued_o   (rd_issued),
    .sdram_cmd_o, .sdram_ba_o, .sdram_addr_o, .sdram_dq_o, .sdram_dqoe_o, .sdram_dm_o
  );

  sdram_rd_return #(
    .MAX_CL (MAX_CL)
  ) u_rd_return (
    .clk_i, .rst_ni,
    .csr_i       (csr),
    .rd_issued_i (rd_issued),
    .sdram_dq_i, .rsp_valid_o, .rsp_o
  );

endmodule

//--- sdram_sched_checks.svh
// LCG state, shadow memory and compare tasks of the testbench

logic [31:0] lcg_state = 32'h9dd1aadd;
logic [DQ_W-1:0] shadow_mem [logic [20:0]];

function logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Contents of a never written word taken from every address bit
function automatic logic [DQ_W-1:0] fill_word(input logic [20:0] key);
  return key[15:0] ^ {key[20:16], 11'h2a5};
endfunction

function automatic void shadow_write(input req_t r);
  logic [20:0]     key;
  logic [DQ_W-1:0] w;
  key = {r.ba, r.row, r.col};
  w = shadow_mem.exists(key) ? shadow_mem[key] : fill_word(key);
  for (int i = 0; i < DM_W; i++)
  begin
    if (r.be[i])
      w[8*i +: 8] = r.wdata[8*i +: 8];
  end
  shadow_mem[key] = w;
endfunction

function automatic logic [DQ_W-1:0] expected_rdata(input req_t r);
  logic [20:0] key;
  key = {r.ba, r.row, r.col};
  return shadow_mem.exists(key) ? shadow_mem[key] : fill_word(key);
endfunction

task automatic check_rsp(input rsp_t exp, input rsp_t got);
  if (got !== exp)
    report_error($sformatf("read data %h, expected %h", got.rdata, exp.rdata));
endtask

task automatic check_csr(input csr_t exp, input csr_t got);
  if (got !== exp)
    report_error($sformatf("CSR readback ena %0d cl %0d rcd %0d rp %0d ras %0d rc %0d ref %0d",
      got.ena, got.cl, got.t_rcd, got.t_rp, got.t_ras, got.t_rc, got.t_ref));
endtask

// Cycle distance between two pin events must lie in lo..hi
task automatic check_cmd_gap(input sdram_cmd_e cmd, input int gap, input int lo, input int hi);
  if ((gap < lo) || (gap > hi))
    report_error($sformatf("%s gap of %0d cycles outside %0d..%0d", cmd.name(), gap, lo, hi));
endtask

//--- sdram_sched_tb.sv
`timescale 1ns/100ps

module sdram_sched_tb;
  import sdram_sched_pkg::*;

  localparam int NUM_RAND = 120;
  localparam int NUM_CL   = 30;
  localparam int NUM_REF  = 60;
  localparam int NUM_REQ  = NUM_RAND + 2 * NUM_CL + NUM_REF + 1;
  localparam int SETUP_CYCLES = 16 + 600;
  localparam int NO_LIMIT = 1 << 30;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic psel, penable, pwrite, pready, pslverr;
  logic [3:0] paddr;
  logic [31:0] pwdata, prdata;
  logic req_valid, req_ready, rsp_valid;
  req_t req;
  rsp_t rsp;
  sdram_cmd_e pin_cmd;
  logic [BA_W-1:0] pin_ba;
  logic [ROW_W-1:0] pin_addr;
  logic [DQ_W-1:0] pin_dq, dq_i;
  logic pin_dqoe;
  logic [DM_W-1:0] pin_dm;

  // Memory model and pin history
  int cyc = 0;
  csr_t cur_csr;
  logic [NUM_BANKS-1:0] mdl_open;
  logic [ROW_W-1:0] mdl_row [NUM_BANKS];
  int last_act [NUM_BANKS];
  int last_pre [NUM_BANKS];
  int last_actref, last_ref, ref_count, errors;
  bit ref_check_en, nop_check;
  logic [DQ_W-1:0] mdl_mem [logic [20:0]];
  logic [DQ_W-1:0] rd_due [int];
  int rd_cyc_q [$];
  logic [DQ_W-1:0] exp_q [$];

  sdram_scheduler_top #(.MAX_CL(3)) dut (
    .clk_i, .rst_ni,
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
    .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
    .req_valid_i (req_valid), .req_i (req), .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid), .rsp_o (rsp),
    .sdram_cmd_o (pin_cmd), .sdram_ba_o (pin_ba), .sdram_addr_o (pin_addr),
    .sdram_dq_o (pin_dq), .sdram_dqoe_o (pin_dqoe), .sdram_dm_o (pin_dm),
    .sdram_dq_i (dq_i)
  );

  always #20 clk_i = ~clk_i;

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "stopped at first error");
  endtask

  `include "sdram_sched_checks.svh"

  function automatic req_t rand_req();
    req_t r;
    logic [31:0] a;
    logic [31:0] b;
    a = lcg_next();
    b = lcg_next();
    r.we    = a[31];
    r.ba    = a[29:28];
    r.row   = ROW_W'(a[25:24]) * 11'd683;
    r.col   = {4'd0, a[19:16]};
    r.wdata = b[31:16];
    r.be    = b[9:8];
    return r;
  endfunction

  ////////////////////
  // Drivers

  task automatic apb_write(input logic [3:0] a, input logic [31:0] d);
    @(posedge clk_i);
    #2;
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = a;
    pwdata = d;
    @(posedge clk_i);
    #2;
    penable = 1'b1;
    @(negedge clk_i);
    if (!pready)
      report_error("APB write not completed in its access phase");
    @(posedge clk_i);
    #2;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    case (a)
      CSR_CTRL:
      begin
        cur_csr.ena = d[0];
        cur_csr.cl  = d[5:4];
      end
      CSR_TIMING:
      begin
        cur_csr.t_rcd = d[3:0];
        cur_csr.t_rp  = d[7:4];
        cur_csr.t_ras = d[11:8];
        cur_csr.t_rc  = d[15:12];
      end
      CSR_TREF: cur_csr.t_ref = d[15:0];
      default: ;
    endcase
  endtask

  task automatic apb_read(input logic [3:0] a, output logic [31:0] d, output logic err);
    @(posedge clk_i);
    #2;
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = a;
    @(posedge clk_i);
    #2;
    penable = 1'b1;
    @(negedge clk_i);
    d = prdata;
    err = pslverr;
    if (!pready)
      report_error("APB read not completed in its access phase");
    @(posedge clk_i);
    #2;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic send_req(input req_t r);
    @(posedge clk_i);
    #2;
    req = r;
    req_valid = 1'b1;
    @(negedge clk_i);
    while (!req_ready)
      @(negedge clk_i);
    if (r.we)
      shadow_write(r);
    else
      exp_q.push_back(expected_rdata(r));
    @(posedge clk_i);
    #2;
    req_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0)
      @(negedge clk_i);
    repeat (4) @(posedge clk_i);
  endtask

  ////////////////////
  // SDRAM model and pin timing checks

  always @(posedge clk_i)
  begin
    logic [20:0]     key;
    logic [DQ_W-1:0] word;
    #2;
    cyc++;
    if (rst_ni)
    begin
      if (nop_check && (pin_cmd != CMD_NOP))
        report_error("command on the pins while disabled");
      if (pin_dqoe != (pin_cmd == CMD_WR))
        report_error("data output enable does not match WR");
      case (pin_cmd)
        CMD_ACT:
        begin
          if (mdl_open[pin_ba])
            report_error("ACT to a bank that is already open");
          check_cmd_gap(CMD_ACT, cyc - last_pre[pin_ba], int'(cur_csr.t_rp), NO_LIMIT);
          check_cmd_gap(CMD_ACT, cyc - last_actref, int'(cur_csr.t_rc), NO_LIMIT);
          mdl_open[pin_ba] = 1'b1;
          mdl_row[pin_ba] = pin_addr;
          last_act[pin_ba] = cyc;
          last_actref = cyc;
        end
        CMD_PRE:
        begin
          for (int b = 0; b < NUM_BANKS; b++)
          begin
            if (pin_addr[10] || (pin_ba == BA_W'(b)))
            begin
              if (mdl_open[b])
                check_cmd_gap(CMD_PRE, cyc - last_act[b], int'(cur_csr.t_ras), NO_LIMIT);
              mdl_open[b] = 1'b0;
              last_pre[b] = cyc;
            end
          end
        end
        CMD_RD, CMD_WR:
        begin
          if (!mdl_open[pin_ba])
            report_error("RD or WR to an idle bank");
          check_cmd_gap(pin_cmd, cyc - last_act[pin_ba], int'(cur_csr.t_rcd), NO_LIMIT);
          key = {pin_ba, mdl_row[pin_ba], pin_addr[COL_W-1:0]};
          word = mdl_mem.exists(key) ? mdl_mem[key] : fill_word(key);
          if (pin_cmd == CMD_WR)
          begin
            for (int i = 0; i < DM_W; i++)
            begin
              if (!pin_dm[i])
                word[8*i +: 8] = pin_dq[8*i +: 8];
            end
            mdl_mem[key] = word;
          end
          else
          begin
            rd_due[cyc + int'(cur_csr.cl)] = word;
            rd_cyc_q.push_back(cyc);
          end
        end
        CMD_REF:
        begin
          if (|mdl_open)
            report_error("REF while a bank is open");
          check_cmd_gap(CMD_REF, cyc - last_actref, int'(cur_csr.t_rc), NO_LIMIT);
          if (ref_check_en && (last_ref >= 0))
            check_cmd_gap(CMD_REF, cyc - last_ref, 1, int'(cur_csr.t_ref) + int'(cur_csr.t_ras)
              + int'(cur_csr.t_rp) + int'(cur_csr.t_rc) + 4);
          last_ref = cyc;
          last_actref = cyc;
          ref_count++;
        end
        default: ;
      endcase
      // Read word goes out cl cycles after RD
      if (rd_due.exists(cyc))
      begin
        dq_i = rd_due[cyc];
        rd_due.delete(cyc);
      end
      else
        dq_i = '0;
    end
  end

  ////////////////////
  // Response compare

  always @(negedge clk_i)
  begin
    rsp_t exp;
    int   rd_cyc;
    if (rst_ni && rsp_valid)
    begin
      if ((exp_q.size() == 0) || (rd_cyc_q.size() == 0))
        report_error("response with no outstanding read");
      else
      begin
        exp.rdata = exp_q.pop_front();
        rd_cyc = rd_cyc_q.pop_front();
        check_rsp(exp, rsp);
        check_cmd_gap(CMD_RD, cyc - rd_cyc, int'(cur_csr.cl) + 1, int'(cur_csr.cl) + 1);
      end
    end
  end

  initial
  begin
    #((SETUP_CYCLES + NUM_REQ * 200) * 40);
    $display("Timeout: the test did not finish in the allowed time");
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////
  // Test sequence

  initial
  begin
    logic [31:0] w0, w1, w2;
    logic        err;
    csr_t        got;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    req_valid = 1'b0;
    req = '0;
    dq_i = '0;
    errors = 0;
    ref_count = 0;
    last_ref = -1;
    last_actref = -1000;
    ref_check_en = 1'b0;
    nop_check = 1'b0;
    mdl_open = '0;
    cur_csr = CSR_RESET;
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      last_act[b] = -1000;
      last_pre[b] = -1000;
      mdl_row[b] = '0;
    end
    rst_ni = 1'b0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    apb_write(CSR_TIMING, 32'h8633);
    apb_write(CSR_TREF, 32'd400);
    apb_write(CSR_CTRL, 32'h21);
    apb_read(CSR_CTRL, w0, err);
    if (err)
      report_error("slave error on the CTRL register");
    apb_read(CSR_TIMING, w1, err);
    if (err)
      report_error("slave error on the TIMING register");
    apb_read(CSR_TREF, w2, err);
    if (err)
      report_error("slave error on the TREF register");
    got.ena = w0[0];
    got.cl = w0[5:4];
    got.t_rcd = w1[3:0];
    got.t_rp = w1[7:4];
    got.t_ras = w1[11:8];
    got.t_rc = w1[15:12];
    got.t_ref = w2[15:0];
    check_csr(cur_csr, got);
    apb_read(4'hC, w0, err);
    if (!err)
      report_error("no slave error for offset 0xC");

    repeat (NUM_RAND) send_req(rand_req());
    drain();

    // CAS latency 3, then back to 2
    apb_write(CSR_CTRL, 32'h31);
    repeat (NUM_CL) send_req(rand_req());
    drain();
    apb_write(CSR_CTRL, 32'h21);
    repeat (NUM_CL) send_req(rand_req());
    drain();

    apb_write(CSR_CTRL, 32'h20);
    repeat (4) @(posedge clk_i);
    nop_check = 1'b1;
    @(posedge clk_i);
    #2;
    req = rand_req();
    req_valid = 1'b1;
    repeat (20)
    begin
      @(negedge clk_i);
      if (req_ready)
        report_error("request accepted while disabled");
    end
    @(posedge clk_i);
    #2;
    req_valid = 1'b0;
    nop_check = 1'b0;

    // Short refresh interval under load
    apb_write(CSR_TREF, 32'd60);
    apb_write(CSR_CTRL, 32'h21);
    ref_count = 0;
    last_ref = -1;
    ref_check_en = 1'b1;
    repeat (NUM_REF) send_req(rand_req());
    drain();
    repeat (100) @(posedge clk_i);
    ref_check_en = 1'b0;
    if (ref_count < 3)
      report_error("too few refreshes with a short interval");

    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

//--- build.f
+incdir+.
sdram_sched_pkg.sv
sdram_csr_apb.sv
sdram_bank_timers.sv
sdram_refresh_ctrl.sv
sdram_cmd_fsm.sv
sdram_rd_return.sv
sdram_scheduler_top.sv
sdram_sched_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -f build.f --top-module sdram_sched_tb -o sdram_sched_sim
./obj_dir/sdram_sched_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation finished"
